// File: mmu_xlate_top.f
common/pte_pkg.sv
common/tlb_cfg_pkg.sv
common/tlb_rsp_if.sv
tlb/find_first_set.sv
tlb/tlb.sv
hdl/tlb_ctrl_regs.sv
hdl/perm_check.sv
hdl/mmu_xlate_top.sv
verification/tb_mmu_xlate_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the MMU translation testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_mmu_xlate_top \
   -f mmu_xlate_top.f \
   -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
   echo "simulation reported failure"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "simulator exited with status $run_status"
   exit 1
fi

exit 0

// File: verification/tb_mmu_xlate_top.sv
module tb_mmu_xlate_top;
   import pte_pkg::*;
   import tlb_cfg_pkg::*;

   typedef enum logic [1:0] {op_fill, op_look, op_wr, op_rd} op_t;

   typedef struct packed
   {
      op_t                       op;
      logic [cfg_addr_width-1:0] addr;
      logic [va_width-1:0]       va;
      pg_size_t                  size;
      logic [4:0]                perm;
      access_t                   acc;
      priv_t                     priv;
      logic [cfg_width-1:0]      data;
   } row_t;

   logic                      clk;
   logic                      reset;
   logic                      req;
   logic [va_width-1:0]       va;
   access_t                   access;
   priv_t                     priv;
   logic                      fill;
   logic [va_width-1:0]       fill_va;
   page_walk_rsp_t            fill_rsp;
   logic                      cfg_we;
   logic [cfg_addr_width-1:0] cfg_addr;
   logic [cfg_width-1:0]      cfg_wdata;
   logic [cfg_width-1:0]      cfg_rdata;
   logic                      hit;
   logic                      miss;
   logic                      fault;
   logic [pa_width-1:0]       pa;
   logic                      zero_page;

   // reference model state
   // perm bits are {dirty, readable, writable, executable, user}
   logic                 m_valid [tlb_entries];
   logic [tag_width-1:0] m_tag [tlb_entries];
   pg_size_t             m_size [tlb_entries];
   logic [pa_width-1:0]  m_base [tlb_entries];
   logic [4:0]           m_perm [tlb_entries];
   int                   m_ptr;
   logic                 m_active;
   logic                 m_flush_d;
   logic [cnt_width-1:0] exp_hits;
   logic [cnt_width-1:0] exp_acc;
   integer               seed;
   row_t                 rows [$];

   mmu_xlate_top u_mmu_xlate_top
   (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .va        (va),
      .access    (access),
      .priv      (priv),
      .fill      (fill),
      .fill_va   (fill_va),
      .fill_rsp  (fill_rsp),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .hit       (hit),
      .miss      (miss),
      .fault     (fault),
      .pa        (pa),
      .zero_page (zero_page)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #2 clk = ~clk;
      end
   end

   // watchdog on the whole run
   initial
   begin : watchdog
      for (int n = 0; n < 5000; n++)
      begin
         @(posedge clk);
      end
      $display("timeout: the stimulus table did not finish within 5000 cycles");
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
   end

   task automatic report_error(input string msg);
      $display("** Error at time %0t: %s", $time, msg);
      $display("RESULT: FAIL");
      $fatal(1, "check failed");
   endtask

   function automatic int offset_bits(input pg_size_t sz);
      case (sz)
         pg_1g:   return 30;
         pg_2m:   return 21;
         pg_64k:  return 16;
         default: return 12;
      endcase
   endfunction

   function automatic logic perm_fault(input logic [4:0] p, input access_t acc, input priv_t pv);
      logic bad;
      bad = 1'b0;
      if (acc == acc_load && !p[3])
         bad = 1'b1;
      if (acc == acc_store && (!p[2] || !p[4]))
         bad = 1'b1;
      if (acc == acc_fetch && !p[1])
         bad = 1'b1;
      if (pv == priv_user && !p[0])
         bad = 1'b1;
      if (pv == priv_super && acc == acc_fetch && p[0])
         bad = 1'b1;
      return bad;
   endfunction

   // advance one clock edge and update the model from the sampled inputs
   task automatic tick();
      int cur;
      @(posedge clk);
      cur = m_ptr;
      if (reset)
      begin
         m_ptr     = 0;
         m_active  = 1'b0;
         m_flush_d = 1'b0;
         for (int i = 0; i < tlb_entries; i++)
            m_valid[i] = 1'b0;
      end
      else
      begin
         if (m_flush_d)
         begin
            for (int i = 0; i < tlb_entries; i++)
               m_valid[i] = 1'b0;
         end
         else if (fill)
            m_valid[cur] = 1'b1;
         if (fill)
         begin
            m_tag[cur]  = fill_va[39:12];
            m_size[cur] = fill_rsp.pgsize;
            m_base[cur] = fill_rsp.paddr[pa_width-1:0];
            m_perm[cur] = {fill_rsp.dirty, fill_rsp.readable, fill_rsp.writable,
                           fill_rsp.executable, fill_rsp.user};
         end
         if (cfg_we && cfg_addr == reg_ctrl)
            m_active = cfg_wdata[0];
         if (cfg_we && (cfg_addr == reg_hits || cfg_addr == reg_accesses))
         begin
            exp_hits = '0;
            exp_acc  = '0;
         end
         m_flush_d = cfg_we && cfg_addr == reg_flush && cfg_wdata[0];
         m_ptr     = (cur + 1) % tlb_entries;
      end
   endtask

   task automatic check_xlate(input logic e_hit, input logic [pa_width-1:0] e_pa,
                              input logic e_miss, input logic e_fault);
      if (hit !== e_hit || miss !== e_miss || fault !== e_fault || (e_hit && pa !== e_pa))
         report_error($sformatf("va %h: hit %b miss %b fault %b pa %h, expected %b %b %b %h",
                                va, hit, miss, fault, pa, e_hit, e_miss, e_fault, e_pa));
   endtask

   task automatic check_reg(input logic [cnt_width-1:0] e_val);
      if (cfg_rdata !== e_val)
         report_error($sformatf("register %0d reads %h, expected %h", cfg_addr, cfg_rdata, e_val));
   endtask

   task automatic check_flag(input logic e_zero);
      if (zero_page !== e_zero)
         report_error($sformatf("va %h: zero_page %b, expected %b", va, zero_page, e_zero));
   endtask

   task automatic issue_lookup(input row_t r);
      int                  idx;
      int                  s;
      logic                e_hit;
      logic                e_fault;
      logic [pa_width-1:0] mask;
      logic [pa_width-1:0] e_pa;
      idx = -1;
      for (int i = 0; i < tlb_entries; i++)
      begin
         s = offset_bits(m_size[i]);
         if (idx < 0 && m_valid[i] && ((m_tag[i] >> (s - 12)) == (r.va[39:12] >> (s - 12))))
            idx = i;
      end
      if (!m_active)
      begin
         e_hit   = 1'b1;
         e_pa    = r.va[pa_width-1:0];
         e_fault = 1'b0;
      end
      else
      begin
         e_hit   = idx >= 0;
         e_pa    = '0;
         e_fault = 1'b0;
         if (e_hit)
         begin
            mask    = (40'd1 << offset_bits(m_size[idx])) - 1;
            e_pa    = (m_base[idx] & ~mask) | (r.va[pa_width-1:0] & mask);
            e_fault = perm_fault(m_perm[idx], r.acc, r.priv);
         end
         exp_acc = exp_acc + 1;
         if (e_hit)
            exp_hits = exp_hits + 1;
      end
      req    <= 1'b1;
      va     <= r.va;
      access <= r.acc;
      priv   <= r.priv;
      tick();
      req <= 1'b0;
      @(negedge clk);
      check_xlate(e_hit, e_pa, !e_hit, e_fault);
      check_flag((r.va & 64'h0000_00ff_ffff_f000) == 64'h0);
   endtask

   task automatic drive_fill(input row_t r);
      page_walk_rsp_t w;
      w.paddr      = {$random(seed), $random(seed)};
      w.pgsize     = r.size;
      w.dirty      = r.perm[4];
      w.readable   = r.perm[3];
      w.writable   = r.perm[2];
      w.executable = r.perm[1];
      w.user       = r.perm[0];
      fill     <= 1'b1;
      fill_va  <= r.va;
      fill_rsp <= w;
      tick();
      fill <= 1'b0;
   endtask

   function automatic void fill_row(input logic [63:0] a, input pg_size_t sz, input logic [4:0] p);
      rows.push_back('{op_fill, reg_ctrl, a, sz, p, acc_load, priv_mach, '0});
   endfunction

   function automatic void lookup_row(input logic [63:0] a, input access_t ac, input priv_t pv);
      rows.push_back('{op_look, reg_ctrl, a, pg_4k, 5'b0, ac, pv, '0});
   endfunction

   function automatic void reg_row(input op_t op, input logic [1:0] ad, input logic [31:0] d);
      rows.push_back('{op, ad, 64'h0, pg_4k, 5'b0, acc_load, priv_mach, d});
   endfunction

   initial
   begin
      seed = 32'h91bf_145a;
      reset = 1'b1;
      req = 1'b0;
      va = '0;
      access = acc_load;
      priv = priv_mach;
      fill = 1'b0;
      fill_va = '0;
      fill_rsp = '0;
      cfg_we = 1'b0;
      cfg_addr = '0;
      cfg_wdata = '0;
      m_ptr = 0;
      m_active = 1'b0;
      m_flush_d = 1'b0;
      exp_hits = '0;
      exp_acc = '0;
      for (int i = 0; i < tlb_entries; i++)
         m_valid[i] = 1'b0;

      // bypass mode
      lookup_row(64'h0000_00ab_cdef_1234, acc_load, priv_user);
      lookup_row(64'h0000_0000_0000_0000, acc_fetch, priv_super);
      lookup_row(64'hffff_ff12_3456_7000, acc_store, priv_user);
      reg_row(op_rd, reg_ctrl, 32'h0);
      // one page of each size
      // reads in between space the fills onto separate entries
      reg_row(op_wr, reg_ctrl, 32'h1);
      reg_row(op_rd, reg_ctrl, 32'h0);
      fill_row(64'h0000_0080_4000_0000, pg_1g, 5'b11111);
      reg_row(op_rd, reg_ctrl, 32'h0);
      fill_row(64'h0000_0012_3440_0000, pg_2m, 5'b11111);
      reg_row(op_rd, reg_ctrl, 32'h0);
      fill_row(64'h0000_0001_2345_6000, pg_4k, 5'b11111);
      reg_row(op_rd, reg_ctrl, 32'h0);
      fill_row(64'h0000_0003_0005_0000, pg_64k, 5'b11111);
      lookup_row(64'h0000_0080_7fff_fff8, acc_load, priv_user);
      lookup_row(64'h0000_0080_8000_0000, acc_load, priv_user);
      lookup_row(64'h0000_0012_345f_fff0, acc_store, priv_user);
      lookup_row(64'h0000_0012_3460_0000, acc_load, priv_user);
      lookup_row(64'h0000_0001_2345_6abc, acc_fetch, priv_user);
      lookup_row(64'h0000_0001_2345_7000, acc_load, priv_user);
      lookup_row(64'h0000_0003_0005_fffc, acc_load, priv_mach);
      lookup_row(64'h0000_0003_0006_0000, acc_load, priv_mach);
      reg_row(op_rd, reg_hits, 32'h0);
      reg_row(op_rd, reg_accesses, 32'h0);
      // flush then permission pages
      reg_row(op_wr, reg_flush, 32'h1);
      lookup_row(64'h0000_0001_2345_6abc, acc_load, priv_user);
      fill_row(64'h0000_0010_0000_1000, pg_4k, 5'b01000);
      reg_row(op_rd, reg_ctrl, 32'h0);
      fill_row(64'h0000_0010_0000_2000, pg_4k, 5'b11111);
      reg_row(op_rd, reg_ctrl, 32'h0);
      fill_row(64'h0000_0010_0000_3000, pg_4k, 5'b00100);
      lookup_row(64'h0000_0010_0000_1010, acc_load, priv_super);
      lookup_row(64'h0000_0010_0000_1020, acc_store, priv_super);
      lookup_row(64'h0000_0010_0000_1030, acc_fetch, priv_super);
      lookup_row(64'h0000_0010_0000_1040, acc_load, priv_user);
      lookup_row(64'h0000_0010_0000_2010, acc_fetch, priv_user);
      lookup_row(64'h0000_0010_0000_2020, acc_fetch, priv_super);
      lookup_row(64'h0000_0010_0000_2030, acc_store, priv_user);
      lookup_row(64'h0000_0010_0000_2040, acc_load, priv_mach);
      lookup_row(64'h0000_0010_0000_3010, acc_store, priv_super);
      lookup_row(64'h0000_0010_0000_3020, acc_load, priv_super);
      // overfill to force evictions
      fill_row(64'h0000_0020_0000_1000, pg_4k, 5'b11111);
      fill_row(64'h0000_0020_0000_2000, pg_4k, 5'b11111);
      fill_row(64'h0000_0020_0000_3000, pg_4k, 5'b11111);
      lookup_row(64'h0000_0010_0000_1000, acc_load, priv_mach);
      lookup_row(64'h0000_0010_0000_2000, acc_load, priv_mach);
      lookup_row(64'h0000_0010_0000_3000, acc_load, priv_mach);
      lookup_row(64'h0000_0020_0000_1000, acc_load, priv_mach);
      lookup_row(64'h0000_0020_0000_2000, acc_load, priv_mach);
      lookup_row(64'h0000_0020_0000_3000, acc_load, priv_mach);
      lookup_row(64'hffff_ff00_0000_0abc, acc_load, priv_mach);
      reg_row(op_rd, reg_hits, 32'h0);
      reg_row(op_rd, reg_accesses, 32'h0);
      // counter clear then disable again
      reg_row(op_wr, reg_accesses, 32'h0);
      reg_row(op_rd, reg_hits, 32'h0);
      reg_row(op_rd, reg_accesses, 32'h0);
      lookup_row(64'h0000_0020_0000_3008, acc_load, priv_mach);
      reg_row(op_rd, reg_accesses, 32'h0);
      reg_row(op_wr, reg_ctrl, 32'h0);
      lookup_row(64'h0000_0000_0000_0fff, acc_store, priv_user);
      reg_row(op_rd, reg_ctrl, 32'h0);

      for (int n = 0; n < 4; n++)
         tick();
      reset <= 1'b0;

      foreach (rows[i])
      begin
         tick();
         case (rows[i].op)
            op_fill: drive_fill(rows[i]);
            op_look: issue_lookup(rows[i]);
            op_wr:
            begin
               cfg_we    <= 1'b1;
               cfg_addr  <= rows[i].addr;
               cfg_wdata <= rows[i].data;
               tick();
               cfg_we <= 1'b0;
            end
            default:
            begin
               cfg_addr <= rows[i].addr;
               @(negedge clk);
               case (rows[i].addr)
                  reg_ctrl: check_reg(cnt_width'(m_active));
                  reg_hits: check_reg(exp_hits);
                  default:  check_reg(exp_acc);
               endcase
            end
         endcase
      end

      tick();
      $display("RESULT: PASS");
      $finish;
   end

endmodule

// File: hdl/mmu_xlate_top.sv
module mmu_xlate_top
(
   input  logic                                  clk,
   input  logic                                  reset,
   // lookup side
   input  logic                                  req,
   input  logic [tlb_cfg_pkg::va_width-1:0]       va,
   input  pte_pkg::access_t                      access,
   input  pte_pkg::priv_t                        priv,
   // fill side
   input  logic                                  fill,
   input  logic [tlb_cfg_pkg::va_width-1:0]       fill_va,
   input  pte_pkg::page_walk_rsp_t               fill_rsp,
   // register side
   input  logic                                  cfg_we,
   input  logic [tlb_cfg_pkg::cfg_addr_width-1:0] cfg_addr,
   input  logic [tlb_cfg_pkg::cfg_width-1:0]      cfg_wdata,
   output logic [tlb_cfg_pkg::cfg_width-1:0]      cfg_rdata,
   // results
   output logic                                  hit,
   output logic                                  miss,
   output logic                                  fault,
   output logic [tlb_cfg_pkg::pa_width-1:0]       pa,
   output logic                                  zero_page
);

   logic active;
   logic flush;

   tlb_rsp_if rsp_if ();

   tlb u_tlb
   (
      .clk      (clk),
      .reset    (reset),
      .active   (active),
      .flush    (flush),
      .req      (req),
      .va       (va),
      .fill     (fill),
      .fill_va  (fill_va),
      .fill_rsp (fill_rsp),
      .rsp      (rsp_if.tlb)
   );

   tlb_ctrl_regs u_tlb_ctrl_regs
   (
      .clk       (clk),
      .reset     (reset),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .req       (req),
      .hit       (rsp_if.hit),
      .active    (active),
      .flush     (flush)
   );

   perm_check u_perm_check
   (
      .clk    (clk),
      .reset  (reset),
      .req    (req),
      .access (access),
      .priv   (priv),
      .rsp    (rsp_if.chk),
      .active (active),
      .miss   (miss),
      .fault  (fault)
   );

   // registered tlb result straight to the pins
   assign hit       = rsp_if.hit;
   assign pa        = rsp_if.pa;
   assign zero_page = rsp_if.zero_page;

endmodule

// File: hdl/perm_check.sv
module perm_check
(
   input  logic             clk,
   input  logic             reset,
   input  logic             req,
   input  pte_pkg::access_t access,
   input  pte_pkg::priv_t   priv,
   tlb_rsp_if.chk           rsp,
   input  logic             active,
   output logic             miss,
   output logic             fault
);
   import pte_pkg::*;

   logic    r_req;
   access_t r_access;
   priv_t   r_priv;
   logic    perm_err;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_req <= 1'b0;
      end
      else
      begin
         r_req <= req;
      end
   end

   always_ff @(posedge clk)
   begin
      r_access <= access;
      r_priv   <= priv;
   end

   always_comb
   begin
      case (r_access)
         acc_load:  perm_err = !rsp.readable;
         acc_store: perm_err = !rsp.writable || !rsp.dirty;
         acc_fetch: perm_err = !rsp.executable;
         default:   perm_err = 1'b0;
      endcase
      // user code may only touch user pages
      if ((r_priv == priv_user) && !rsp.user)
      begin
         perm_err = 1'b1;
      end
      // supervisor never executes from user pages
      if ((r_priv == priv_super) && (r_access == acc_fetch) && rsp.user)
      begin
         perm_err = 1'b1;
      end
   end

   assign miss  = r_req && !rsp.hit;
   assign fault = r_req && rsp.hit && active && perm_err;

   // a tlb hit only ever answers a request from the previous cycle
   hit_after_req: assert property (@(posedge clk) disable iff (reset) rsp.hit |-> r_req);

endmodule

// File: hdl/tlb_ctrl_regs.sv
module tlb_ctrl_regs
(
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  cfg_we,
   input  logic [tlb_cfg_pkg::cfg_addr_width-1:0] cfg_addr,
   input  logic [tlb_cfg_pkg::cfg_width-1:0]      cfg_wdata,
   output logic [tlb_cfg_pkg::cfg_width-1:0]      cfg_rdata,
   input  logic                                  req,
   input  logic                                  hit,
   output logic                                  active,
   output logic                                  flush
);
   import tlb_cfg_pkg::*;

   logic                 r_req_d;
   logic                 cnt_clear;
   logic [cnt_width-1:0] r_hits;
   logic [cnt_width-1:0] r_accesses;

   // writing either counter clears both
   assign cnt_clear = cfg_we && ((cfg_addr == reg_hits) || (cfg_addr == reg_accesses));

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         active  <= 1'b0;
         flush   <= 1'b0;
         r_req_d <= 1'b0;
      end
      else
      begin
         if (cfg_we && (cfg_addr == reg_ctrl))
         begin
            active <= cfg_wdata[0];
         end
         flush   <= cfg_we && (cfg_addr == reg_flush) && cfg_wdata[0];
         // lines up with the registered tlb hit
         r_req_d <= req && active;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset || cnt_clear)
      begin
         r_hits     <= '0;
         r_accesses <= '0;
      end
      else if (r_req_d)
      begin
         r_accesses <= r_accesses + 1'b1;
         if (hit)
         begin
            r_hits <= r_hits + 1'b1;
         end
      end
   end

   always_comb
   begin
      case (cfg_addr)
         reg_ctrl:     cfg_rdata = cfg_width'(active);
         reg_hits:     cfg_rdata = cfg_width'(r_hits);
         reg_accesses: cfg_rdata = cfg_width'(r_accesses);
         default:      cfg_rdata = '0;
      endcase
   end

   // a flush write is a single strobe on the register bus
   flush_pulse: assert property (@(posedge clk) disable iff (reset) flush |=> !flush);

endmodule

// File: tlb/tlb.sv
module tlb
(
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            active,
   input  logic                            flush,
   input  logic                            req,
   input  logic [tlb_cfg_pkg::va_width-1:0] va,
   input  logic                            fill,
   input  logic [tlb_cfg_pkg::va_width-1:0] fill_va,
   input  pte_pkg::page_walk_rsp_t         fill_rsp,
   tlb_rsp_if.tlb                          rsp
);
   import pte_pkg::*;
   import tlb_cfg_pkg::*;

   // entry storage
   logic [tlb_entries-1:0] r_valid;
   logic [tag_width-1:0]   r_tag [tlb_entries];
   pg_size_t               r_size [tlb_entries];
   logic [ppn_width-1:0]   r_ppn [tlb_entries];
   logic [tlb_entries-1:0] r_dirty;
   logic [tlb_entries-1:0] r_readable;
   logic [tlb_entries-1:0] r_writable;
   logic [tlb_entries-1:0] r_executable;
   logic [tlb_entries-1:0] r_user;

   logic [tlb_entries-1:0] line_hit;
   logic [lg_entries-1:0]  hit_idx;
   logic                   hit_any;
   pg_size_t               sel_size;
   logic [ppn_width-1:0]   sel_ppn;
   logic [pa_width-1:0]    pa_sel;
   logic [lg_entries-1:0]  r_repl;

   // per entry match, only the tag bits above the page offset count
   always_comb
   begin
      for (int i = 0; i < tlb_entries; i++)
      begin
         case (r_size[i])
            pg_1g:   line_hit[i] = r_valid[i] && (r_tag[i][27:18] == va[39:30]);
            pg_2m:   line_hit[i] = r_valid[i] && (r_tag[i][27:9] == va[39:21]);
            pg_64k:  line_hit[i] = r_valid[i] && (r_tag[i][27:4] == va[39:16]);
            default: line_hit[i] = r_valid[i] && (r_tag[i] == va[39:12]);
         endcase
      end
   end

   find_first_set u_find_first_set
   (
      .in  (line_hit),
      .y   (hit_idx),
      .any (hit_any)
   );

   assign sel_size = r_size[hit_idx];
   assign sel_ppn  = r_ppn[hit_idx];

   // page number above the offset, virtual offset below it
   always_comb
   begin
      case (sel_size)
         pg_1g:   pa_sel = {sel_ppn[ppn_width-1:18], va[29:0]};
         pg_2m:   pa_sel = {sel_ppn[ppn_width-1:9], va[20:0]};
         pg_64k:  pa_sel = {sel_ppn[ppn_width-1:4], va[15:0]};
         default: pa_sel = {sel_ppn, va[page_shift-1:0]};
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rsp.hit       <= 1'b0;
         rsp.zero_page <= 1'b0;
      end
      else
      begin
         // bypass mode treats every request as a hit
         rsp.hit       <= active ? (req && hit_any) : req;
         rsp.zero_page <= (va[39:12] == '0);
      end
   end

   always_ff @(posedge clk)
   begin
      rsp.pa         <= active ? pa_sel : va[pa_width-1:0];
      rsp.dirty      <= r_dirty[hit_idx];
      rsp.readable   <= r_readable[hit_idx];
      rsp.writable   <= r_writable[hit_idx];
      rsp.executable <= r_executable[hit_idx];
      rsp.user       <= r_user[hit_idx];
   end

   // free running victim pointer, advances whether or not a fill happens
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_repl <= '0;
      end
      else if (r_repl == lg_entries'(tlb_entries - 1))
      begin
         r_repl <= '0;
      end
      else
      begin
         r_repl <= r_repl + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset || flush)
      begin
         r_valid <= '0;
      end
      else if (fill)
      begin
         r_valid[r_repl] <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (fill)
      begin
         r_tag[r_repl]        <= fill_va[39:12];
         r_size[r_repl]       <= fill_rsp.pgsize;
         r_ppn[r_repl]        <= fill_rsp.paddr[pa_width-1:page_shift];
         r_dirty[r_repl]      <= fill_rsp.dirty;
         r_readable[r_repl]   <= fill_rsp.readable;
         r_writable[r_repl]   <= fill_rsp.writable;
         r_executable[r_repl] <= fill_rsp.executable;
         r_user[r_repl]       <= fill_rsp.user;
      end
   end

   // walker fills and register flushes come from different sources
   fill_flush_excl: assert property (@(posedge clk) disable iff (reset) !(fill && flush));

endmodule

// File: tlb/find_first_set.sv
module find_first_set
(
   input  logic [tlb_cfg_pkg::tlb_entries-1:0] in,
   output logic [tlb_cfg_pkg::lg_entries-1:0]  y,
   output logic                                any
);
   import tlb_cfg_pkg::*;

   // scan from the top so the lowest set line wins
   always_comb
   begin
      y = '0;
      for (int i = tlb_entries - 1; i >= 0; i--)
      begin
         if (in[i])
         begin
            y = lg_entries'(i);
         end
      end
   end

   assign any = |in;

endmodule

// File: common/tlb_rsp_if.sv
interface tlb_rsp_if;
   import tlb_cfg_pkg::*;

   // registered lookup result, valid the cycle after a request
   logic                hit;
   logic [pa_width-1:0] pa;
   logic                dirty;
   logic                readable;
   logic                writable;
   logic                executable;
   logic                user;
   logic                zero_page;

   modport tlb
   (
      output hit, pa, dirty, readable, writable, executable, user, zero_page
   );

   modport chk
   (
      input hit, pa, dirty, readable, writable, executable, user, zero_page
   );

endinterface

// File: common/tlb_cfg_pkg.sv
package tlb_cfg_pkg;

   // tlb geometry
   localparam int tlb_entries = 4;
   localparam int lg_entries  = $clog2(tlb_entries);

   // address widths
   localparam int va_width   = 64;
   localparam int pa_width   = 40;
   localparam int page_shift = 12;
   localparam int ppn_width  = pa_width - page_shift;

   // tag covers va bits 39 down to 12
   localparam int tag_width = 28;

   // counters and register bus
   localparam int cnt_width      = 32;
   localparam int cfg_width      = 32;
   localparam int cfg_addr_width = 2;

   // register map
   localparam logic [cfg_addr_width-1:0] reg_ctrl     = 2'd0;
   localparam logic [cfg_addr_width-1:0] reg_flush    = 2'd1;
   localparam logic [cfg_addr_width-1:0] reg_hits     = 2'd2;
   localparam logic [cfg_addr_width-1:0] reg_accesses = 2'd3;

endpackage

// File: common/pte_pkg.sv
package pte_pkg;

   // page sizes as encoded by the page walker
   typedef enum logic [1:0]
   {
      pg_1g  = 2'd0,
      pg_2m  = 2'd1,
      pg_4k  = 2'd2,
      pg_64k = 2'd3
   } pg_size_t;

   // leaf pte as returned by the walker
   typedef struct packed
   {
      logic [63:0] paddr;
      pg_size_t    pgsize;
      logic        dirty;
      logic        readable;
      logic        writable;
      logic        executable;
      logic        user;
   } page_walk_rsp_t;

   // kind of memory access behind a lookup
   typedef enum logic [1:0]
   {
      acc_load  = 2'd0,
      acc_store = 2'd1,
      acc_fetch = 2'd2
   } access_t;

   // privilege level of the access
   typedef enum logic [1:0]
   {
      priv_user  = 2'd0,
      priv_super = 2'd1,
      priv_mach  = 2'd3
   } priv_t;

endpackage
